/* hdl/prof_pkg.sv */
package prof_pkg;

  // Width of every event counter and of the dump value word
  localparam int COUNT_W = 32;

  // Committed PC width
  localparam int VADDR_W = 39;

  // Stall reason encoding width
  localparam int STALL_W = 4;

  // One counter per stall reason
  localparam int NUM_REASONS = 12;

  // Stall reasons, highest priority first
  // Encoded values follow declaration order, 0 to 11
  typedef enum logic [STALL_W-1:0] {
    ic_miss,
    br_ovr,
    fe_cmd,
    mispredict,
    control_haz,
    long_haz,
    data_haz,
    load_dep,
    mul_dep,
    struct_haz,
    dc_miss,
    // Non-committing cycle with no cause flagged
    unknown
  } stall_reason_e;

  // mcycle and minstret plus one counter per reason
  localparam int NUM_CNT = 2 + NUM_REASONS;
  localparam int CNT_IDX_W = $clog2(NUM_CNT);

  // Counter positions in the bank and in the dump stream
  // Stall counter for reason r sits at STALL_BASE + r
  typedef enum logic [CNT_IDX_W-1:0] {
    MCYCLE_IDX   = 0,
    MINSTRET_IDX = 1,
    STALL_BASE   = 2
  } cnt_idx_e;

  // Words the dump engine may send before the collector returns credit
  localparam int DUMP_CREDITS = 4;

  // Must hold the full count 0 to DUMP_CREDITS
  localparam int CREDIT_W = $clog2(DUMP_CREDITS + 1);

  // Dump engine states
  typedef enum logic {
    IDLE,
    SEND
  } dump_state_e;

endpackage

/* hdl/stall_classifier.sv */
module stall_classifier (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Commit stage view
  input  logic                          commit_v_i,
  input  logic [prof_pkg::VADDR_W-1:0]  commit_pc_i,

  // Stall cause flags
  input  logic                          ic_miss_i,
  input  logic                          br_ovr_i,
  input  logic                          fe_cmd_i,
  input  logic                          mispredict_i,
  input  logic                          control_haz_i,
  input  logic                          long_haz_i,
  input  logic                          data_haz_i,
  input  logic                          load_dep_i,
  input  logic                          mul_dep_i,
  input  logic                          struct_haz_i,
  input  logic                          dc_miss_i,

  input  logic                          freeze_i,
  input  logic                          en_i,

  // Registered view of the classified cycle
  output logic                          instret_o,
  output prof_pkg::stall_reason_e       reason_o,
  output logic [prof_pkg::VADDR_W-1:0]  pc_o,
  output logic                          en_o,
  output logic                          v_o
);

  prof_pkg::stall_reason_e reason_n;

  // First asserted cause wins
  // Order here mirrors the enum order
  always_comb begin
    if (ic_miss_i) begin
      reason_n = prof_pkg::ic_miss;
    end else if (br_ovr_i) begin
      reason_n = prof_pkg::br_ovr;
    end else if (fe_cmd_i) begin
      reason_n = prof_pkg::fe_cmd;
    end else if (mispredict_i) begin
      reason_n = prof_pkg::mispredict;
    end else if (control_haz_i) begin
      reason_n = prof_pkg::control_haz;
    end else if (long_haz_i) begin
      reason_n = prof_pkg::long_haz;
    end else if (data_haz_i) begin
      reason_n = prof_pkg::data_haz;
    end else if (load_dep_i) begin
      reason_n = prof_pkg::load_dep;
    end else if (mul_dep_i) begin
      reason_n = prof_pkg::mul_dep;
    end else if (struct_haz_i) begin
      reason_n = prof_pkg::struct_haz;
    end else if (dc_miss_i) begin
      reason_n = prof_pkg::dc_miss;
    end else begin
      reason_n = prof_pkg::unknown;
    end
  end

  // One cycle of latency for the whole commit view
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instret_o <= 1'b0;
      reason_o  <= prof_pkg::unknown;
      en_o      <= 1'b0;
      v_o       <= 1'b1;
    end else begin
      instret_o <= commit_v_i;
      // Retiring cycles carry no stall reason
      reason_o  <= commit_v_i ? prof_pkg::unknown : reason_n;
      // Enable travels with the cycle it qualifies
      en_o      <= en_i;
      // Profile data valid while not frozen
      v_o       <= ~freeze_i;
    end
  end

  // Committed PC, plain pipeline stage
  always_ff @(posedge clk_i) begin
    pc_o <= commit_pc_i;
  end

endmodule

/* hdl/counter_bank.sv */
module counter_bank (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,

  // Clear request, acts at the next edge
  input  logic                                              freeze_i,

  // Classified cycle from the classifier stage
  input  logic                                              en_i,
  input  logic                                              instret_i,
  input  prof_pkg::stall_reason_e                           reason_i,

  // All counters, index order as in cnt_idx_e
  output logic [prof_pkg::NUM_CNT-1:0][prof_pkg::COUNT_W-1:0] counts_o
);

  // Per-counter increment strobes
  logic [prof_pkg::NUM_CNT-1:0] up;

  // Enabled cycle that did not retire
  logic stall_v;

  // Counter storage
  logic [prof_pkg::COUNT_W-1:0] cnt_q [prof_pkg::NUM_CNT];

  assign stall_v = en_i & ~instret_i;

  // Every enabled cycle
  assign up[prof_pkg::MCYCLE_IDX] = en_i;

  // Enabled cycles that retired an instruction
  assign up[prof_pkg::MINSTRET_IDX] = en_i & instret_i;

  // Exactly one stall counter moves on a non-retiring cycle
  for (genvar r = 0; r < prof_pkg::NUM_REASONS; r++) begin : g_stall_up
    assign up[prof_pkg::STALL_BASE + r] =
      stall_v & (reason_i == prof_pkg::stall_reason_e'(r));
  end

  // Wrapping counters
  for (genvar i = 0; i < prof_pkg::NUM_CNT; i++) begin : g_cnt
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q[i] <= '0;
      end else if (freeze_i) begin
        // Freeze is not delayed, so it beats any pending increment
        cnt_q[i] <= '0;
      end else if (up[i]) begin
        // Natural rollover at 2**COUNT_W
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end

    assign counts_o[i] = cnt_q[i];
  end

endmodule

/* hdl/counter_dump.sv */
module counter_dump (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,

  // Live counters from the bank
  input  logic [prof_pkg::NUM_CNT-1:0][prof_pkg::COUNT_W-1:0] counts_i,

  // Dump request, honored only while idle
  input  logic                                                dump_req_i,

  // One pulse per word consumed by the collector
  input  logic                                                dump_credit_i,

  // Word stream toward the collector
  output logic                                                dump_v_o,
  output logic [prof_pkg::CNT_IDX_W-1:0]                      dump_idx_o,
  output logic [prof_pkg::COUNT_W-1:0]                        dump_data_o,
  output logic                                                dump_busy_o
);

  prof_pkg::dump_state_e state_q;

  // Next counter to send
  logic [prof_pkg::CNT_IDX_W-1:0] idx_q;

  // Credits currently held
  logic [prof_pkg::CREDIT_W-1:0] credits_q;

  // Frozen copy of the bank for the current dump
  logic [prof_pkg::NUM_CNT-1:0][prof_pkg::COUNT_W-1:0] snap_q;

  logic start;
  logic send;
  logic last;

  // Request accepted this edge
  assign start = (state_q == prof_pkg::IDLE) & dump_req_i;

  // A word goes out whenever a credit is available in SEND
  assign send = (state_q == prof_pkg::SEND) & (credits_q != '0);

  // Final counter of the stream
  assign last = idx_q == prof_pkg::CNT_IDX_W'(prof_pkg::NUM_CNT - 1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= prof_pkg::IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        prof_pkg::IDLE: begin
          if (start) begin
            state_q <= prof_pkg::SEND;
            idx_q   <= prof_pkg::CNT_IDX_W'(prof_pkg::MCYCLE_IDX);
          end
        end
        prof_pkg::SEND: begin
          // Index holds under back-pressure
          if (send) begin
            if (last) begin
              state_q <= prof_pkg::IDLE;
              idx_q   <= '0;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end
        end
        default: begin
          state_q <= prof_pkg::IDLE;
        end
      endcase
    end
  end

  // Snapshot taken on the accepting edge
  always_ff @(posedge clk_i) begin
    if (start) begin
      snap_q <= counts_i;
    end
  end

  // Credit return and spend in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_q <= prof_pkg::CREDIT_W'(prof_pkg::DUMP_CREDITS);
    end else begin
      case ({dump_credit_i, send})
        2'b10:   credits_q <= credits_q + 1'b1;
        2'b01:   credits_q <= credits_q - 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  assign dump_v_o    = send;
  assign dump_idx_o  = idx_q;
  assign dump_data_o = snap_q[idx_q];
  assign dump_busy_o = state_q == prof_pkg::SEND;

endmodule

/* hdl/commit_profiler.sv */
module commit_profiler (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Commit stage
  input  logic                          commit_v_i,
  input  logic [prof_pkg::VADDR_W-1:0]  commit_pc_i,

  // Stall causes
  input  logic                          ic_miss_i,
  input  logic                          br_ovr_i,
  input  logic                          fe_cmd_i,
  input  logic                          mispredict_i,
  input  logic                          control_haz_i,
  input  logic                          long_haz_i,
  input  logic                          data_haz_i,
  input  logic                          load_dep_i,
  input  logic                          mul_dep_i,
  input  logic                          struct_haz_i,
  input  logic                          dc_miss_i,

  // Profiler control
  input  logic                          freeze_i,
  input  logic                          en_i,

  // Collector side
  input  logic                          dump_req_i,
  input  logic                          dump_credit_i,

  // Live per-cycle view
  output logic                          v_o,
  output logic                          instret_o,
  output prof_pkg::stall_reason_e       stall_o,
  output logic [prof_pkg::VADDR_W-1:0]  pc_o,

  // Counter dump stream
  output logic                          dump_v_o,
  output logic [prof_pkg::CNT_IDX_W-1:0] dump_idx_o,
  output logic [prof_pkg::COUNT_W-1:0]  dump_data_o,
  output logic                          dump_busy_o
);

  // Enable aligned with the classified cycle
  logic en_d;

  // Live counter vector
  logic [prof_pkg::NUM_CNT-1:0][prof_pkg::COUNT_W-1:0] counts;

  stall_classifier u_classifier (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .commit_v_i    (commit_v_i),
    .commit_pc_i   (commit_pc_i),
    .ic_miss_i     (ic_miss_i),
    .br_ovr_i      (br_ovr_i),
    .fe_cmd_i      (fe_cmd_i),
    .mispredict_i  (mispredict_i),
    .control_haz_i (control_haz_i),
    .long_haz_i    (long_haz_i),
    .data_haz_i    (data_haz_i),
    .load_dep_i    (load_dep_i),
    .mul_dep_i     (mul_dep_i),
    .struct_haz_i  (struct_haz_i),
    .dc_miss_i     (dc_miss_i),
    .freeze_i      (freeze_i),
    .en_i          (en_i),
    .instret_o     (instret_o),
    .reason_o      (stall_o),
    .pc_o          (pc_o),
    .en_o          (en_d),
    .v_o           (v_o)
  );

  // Freeze goes straight in, not through the classifier stage
  counter_bank u_bank (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .freeze_i  (freeze_i),
    .en_i      (en_d),
    .instret_i (instret_o),
    .reason_i  (stall_o),
    .counts_o  (counts)
  );

  counter_dump u_dump (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .counts_i      (counts),
    .dump_req_i    (dump_req_i),
    .dump_credit_i (dump_credit_i),
    .dump_v_o      (dump_v_o),
    .dump_idx_o    (dump_idx_o),
    .dump_data_o   (dump_data_o),
    .dump_busy_o   (dump_busy_o)
  );

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, 8 units per period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held low for the first 16 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* tests/tb_commit_profiler.sv */
module tb_commit_profiler;

  logic                                clk_i;
  logic                                rst_n_i;
  logic                                commit_v_i;
  logic [prof_pkg::VADDR_W-1:0]        commit_pc_i;
  // Bit r drives the cause flag of stall reason r
  logic [prof_pkg::NUM_REASONS-2:0]    cause_v;
  logic                                freeze_i;
  logic                                en_i;
  logic                                dump_req_i;
  logic                                dump_credit_i;
  logic                                v_o;
  logic                                instret_o;
  prof_pkg::stall_reason_e             stall_o;
  logic [prof_pkg::VADDR_W-1:0]        pc_o;
  logic                                dump_v_o;
  logic [prof_pkg::CNT_IDX_W-1:0]      dump_idx_o;
  logic [prof_pkg::COUNT_W-1:0]        dump_data_o;
  logic                                dump_busy_o;

  // Reference counters, same index order as the dump
  logic [prof_pkg::COUNT_W-1:0]        model_cnt [prof_pkg::NUM_CNT];
  logic [prof_pkg::COUNT_W-1:0]        snap_exp [prof_pkg::NUM_CNT];
  // Inputs driven two edges back, next to reach the counters
  logic                                hist_en;
  logic                                hist_commit;
  logic [prof_pkg::NUM_REASONS-2:0]    hist_cause;
  // Credits the dump engine should hold
  int                                  credits_m;

  tb_clock_gen i_clk_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  commit_profiler i_dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .commit_v_i    (commit_v_i),
    .commit_pc_i   (commit_pc_i),
    .ic_miss_i     (cause_v[0]),
    .br_ovr_i      (cause_v[1]),
    .fe_cmd_i      (cause_v[2]),
    .mispredict_i  (cause_v[3]),
    .control_haz_i (cause_v[4]),
    .long_haz_i    (cause_v[5]),
    .data_haz_i    (cause_v[6]),
    .load_dep_i    (cause_v[7]),
    .mul_dep_i     (cause_v[8]),
    .struct_haz_i  (cause_v[9]),
    .dc_miss_i     (cause_v[10]),
    .freeze_i      (freeze_i),
    .en_i          (en_i),
    .dump_req_i    (dump_req_i),
    .dump_credit_i (dump_credit_i),
    .v_o           (v_o),
    .instret_o     (instret_o),
    .stall_o       (stall_o),
    .pc_o          (pc_o),
    .dump_v_o      (dump_v_o),
    .dump_idx_o    (dump_idx_o),
    .dump_data_o   (dump_data_o),
    .dump_busy_o   (dump_busy_o)
  );

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    stop_run($sformatf("Mismatch at time %0t: %s expected 0x%0h actual 0x%0h",
                       $time, name, exp, act));
  endtask

  // Lowest set bit is the highest priority reason
  function automatic prof_pkg::stall_reason_e top_cause(
    input logic [prof_pkg::NUM_REASONS-2:0] c);
    prof_pkg::stall_reason_e r;
    r = prof_pkg::unknown;
    for (int i = prof_pkg::NUM_REASONS - 2; i >= 0; i--) begin
      if (c[i]) begin
        r = prof_pkg::stall_reason_e'(i);
      end
    end
    return r;
  endfunction

  function automatic logic [prof_pkg::NUM_REASONS-2:0] rand_causes();
    logic [prof_pkg::NUM_REASONS-2:0] c;
    if ($urandom_range(0, 1) == 0) begin
      // One cause, or none when shifted past the top bit
      c = (prof_pkg::NUM_REASONS-1)'(1) << $urandom_range(0, prof_pkg::NUM_REASONS - 1);
    end else begin
      c = (prof_pkg::NUM_REASONS-1)'($urandom() & $urandom());
    end
    return c;
  endfunction

  function automatic logic [prof_pkg::VADDR_W-1:0] rand_pc();
    return prof_pkg::VADDR_W'({$urandom(), $urandom()});
  endfunction

  // Advance one edge and move the reference counters with it
  task automatic tick();
    int k;
    @(posedge clk_i);
    // Freeze sampled at this edge wins over the pending cycle
    if (freeze_i) begin
      for (k = 0; k < prof_pkg::NUM_CNT; k++) begin
        model_cnt[k] = '0;
      end
    end else if (hist_en) begin
      k = hist_commit ? int'(prof_pkg::MINSTRET_IDX)
                      : int'(prof_pkg::STALL_BASE) + int'(top_cause(hist_cause));
      model_cnt[prof_pkg::MCYCLE_IDX] = model_cnt[prof_pkg::MCYCLE_IDX] +
                                        prof_pkg::COUNT_W'(1);
      model_cnt[k] = model_cnt[k] + prof_pkg::COUNT_W'(1);
    end
    hist_en = en_i;
    hist_commit = commit_v_i;
    hist_cause = cause_v;
  endtask

  task automatic drive_cycle(input logic commit, input logic [prof_pkg::NUM_REASONS-2:0] cause,
                             input logic en, input logic frz,
                             input logic [prof_pkg::VADDR_W-1:0] pc);
    tick();
    commit_v_i <= commit;
    cause_v <= cause;
    en_i <= en;
    freeze_i <= frz;
    commit_pc_i <= pc;
  endtask

  // Collector side of one dump, credits returned after a random gap
  task automatic run_dump(input int hold_cycles, input int max_gap, input int req_again,
                          input bit all_zero);
    int sent;
    int pending;
    int gap;
    int cycles;
    bit done;
    tick();
    for (int k = 0; k < prof_pkg::NUM_CNT; k++) begin
      snap_exp[k] = all_zero ? '0 : model_cnt[k];
    end
    dump_req_i <= 1'b1;
    sent = 0;
    pending = 0;
    gap = 0;
    cycles = 0;
    tick();
    dump_req_i <= 1'b0;
    do begin
      @(negedge clk_i);
      if (sent < prof_pkg::NUM_CNT) begin
        assert (dump_busy_o == 1'b1) else report_mismatch("dump_busy_o", 1, dump_busy_o);
        // Index holds while stalled, so it always equals the words seen
        assert (dump_idx_o == sent) else report_mismatch("dump_idx_o", sent, dump_idx_o);
      end
      if (dump_v_o) begin
        assert (credits_m > 0) else stop_run("dump_v_o rose with no credit held");
        assert (sent < prof_pkg::NUM_CNT) else stop_run("Dump sent more words than counters");
        assert (dump_data_o == snap_exp[sent])
          else report_mismatch("dump_data_o", snap_exp[sent], dump_data_o);
        sent++;
        pending++;
      end
      if (cycles < hold_cycles) begin
        assert (sent <= prof_pkg::DUMP_CREDITS)
          else stop_run("Dump sent more words than its initial credits");
      end
      credits_m = credits_m + int'(dump_credit_i) - int'(dump_v_o);
      if (cycles == 400) begin
        stop_run("Timeout waiting for the dump to complete");
      end
      cycles++;
      done = (sent == prof_pkg::NUM_CNT) && !dump_busy_o && (pending == 0);
      tick();
      if (pending > 0 && cycles >= hold_cycles && gap == 0) begin
        dump_credit_i <= 1'b1;
        pending--;
        gap = $urandom_range(0, max_gap);
      end else begin
        dump_credit_i <= 1'b0;
        if (gap > 0) begin
          gap--;
        end
      end
      // Second request while busy must be ignored
      dump_req_i <= (cycles == req_again);
    end while (!done);
  endtask

  task automatic reset_state();
    @(negedge clk_i);
    assert (v_o == 1'b1) else report_mismatch("v_o", 1, v_o);
    assert (instret_o == 1'b0) else report_mismatch("instret_o", 0, instret_o);
    assert (stall_o == prof_pkg::unknown)
      else report_mismatch("stall_o", prof_pkg::unknown, stall_o);
    assert (dump_busy_o == 1'b0) else report_mismatch("dump_busy_o", 0, dump_busy_o);
    assert (dump_v_o == 1'b0) else report_mismatch("dump_v_o", 0, dump_v_o);
    run_dump(0, 0, -1, 1'b1);
  endtask

  task automatic classify_priority();
    logic commit_p;
    logic commit_n;
    logic [prof_pkg::NUM_REASONS-2:0] cause_p;
    logic [prof_pkg::NUM_REASONS-2:0] cause_n;
    logic [prof_pkg::VADDR_W-1:0] pc_p;
    logic [prof_pkg::VADDR_W-1:0] pc_n;
    prof_pkg::stall_reason_e exp_r;
    for (int i = 0; i <= 60; i++) begin
      commit_n = (i < 60) && ($urandom_range(0, 3) == 0);
      cause_n = (i < 60) ? rand_causes() : '0;
      pc_n = rand_pc();
      drive_cycle(commit_n, cause_n, 1'b1, 1'b0, pc_n);
      // Outputs here belong to the previous driven cycle
      @(negedge clk_i);
      if (i > 0) begin
        exp_r = commit_p ? prof_pkg::unknown : top_cause(cause_p);
        assert (instret_o == commit_p) else report_mismatch("instret_o", commit_p, instret_o);
        assert (stall_o == exp_r) else report_mismatch("stall_o", exp_r, stall_o);
        assert (pc_o == pc_p) else report_mismatch("pc_o", pc_p, pc_o);
        assert (v_o == 1'b1) else report_mismatch("v_o", 1, v_o);
      end
      commit_p = commit_n;
      cause_p = cause_n;
      pc_p = pc_n;
    end
  endtask

  task automatic count_with_enable();
    for (int i = 0; i < 80; i++) begin
      drive_cycle($urandom_range(0, 2) == 0, rand_causes(), $urandom_range(0, 3) != 0,
                  1'b0, rand_pc());
    end
    // Idle with counting on, lands in mcycle and the unknown counter
    drive_cycle(1'b0, '0, 1'b1, 1'b0, rand_pc());
    drive_cycle(1'b0, '0, 1'b1, 1'b0, rand_pc());
    run_dump(0, 2, -1, 1'b0);
  endtask

  task automatic freeze_clear();
    for (int i = 0; i < 20; i++) begin
      drive_cycle($urandom_range(0, 1) == 0, rand_causes(), 1'b1, 1'b0, rand_pc());
    end
    drive_cycle(1'b0, '0, 1'b0, 1'b1, rand_pc());
    drive_cycle(1'b0, '0, 1'b0, 1'b0, rand_pc());
    @(negedge clk_i);
    assert (v_o == 1'b0) else report_mismatch("v_o", 0, v_o);
    drive_cycle(1'b0, '0, 1'b0, 1'b0, rand_pc());
    @(negedge clk_i);
    assert (v_o == 1'b1) else report_mismatch("v_o", 1, v_o);
    run_dump(0, 1, -1, 1'b1);
  endtask

  task automatic credit_backpressure();
    for (int i = 0; i < 30; i++) begin
      drive_cycle($urandom_range(0, 2) == 0, rand_causes(), 1'b1, 1'b0, rand_pc());
    end
    // Credits withheld for a while, live counters keep moving
    run_dump(12, 3, 3, 1'b0);
    run_dump(0, 6, -1, 1'b0);
  endtask

  initial begin
    int seed_out;
    int wait_cnt;
    commit_v_i = 1'b0;
    commit_pc_i = '0;
    cause_v = '0;
    freeze_i = 1'b0;
    en_i = 1'b0;
    dump_req_i = 1'b0;
    dump_credit_i = 1'b0;
    hist_en = 1'b0;
    hist_commit = 1'b0;
    hist_cause = '0;
    credits_m = prof_pkg::DUMP_CREDITS;
    for (int k = 0; k < prof_pkg::NUM_CNT; k++) begin
      model_cnt[k] = '0;
    end
    seed_out = $urandom(15737);
    wait_cnt = 0;
    while (rst_n_i !== 1'b1) begin
      if (wait_cnt == 40) begin
        stop_run("Timeout waiting for reset release");
      end
      wait_cnt++;
      @(posedge clk_i);
    end
    reset_state();
    classify_priority();
    count_with_enable();
    freeze_clear();
    credit_backpressure();
    $display("All checks passed");
    $finish;
  end

endmodule

/* filelist.f */
hdl/prof_pkg.sv
hdl/stall_classifier.sv
hdl/counter_bank.sv
hdl/counter_dump.sv
hdl/commit_profiler.sv
tests/tb_clock_gen.sv
tests/tb_commit_profiler.sv

/* Makefile */
# Verilator build and run of the commit profiler testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
	  -f filelist.f --top-module tb_commit_profiler -Mdir obj_dir
	./obj_dir/Vtb_commit_profiler | tee $(LOG)
	@if grep -q "All checks passed" $(LOG); then \
	  echo "TEST PASSED"; \
	else \
	  echo "TEST FAILED"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
